/* source/cache_pkg.sv */
package cache_pkg;

	// address split: tag [31:11], set [10:6], word [5:2], byte [1:0]
	localparam int tag_width = 21;
	localparam int set_index_width = 5;
	localparam int num_sets = 32;
	localparam int num_ways = 4;
	localparam int line_words = 16;
	localparam int word_offset_width = 4;

	// names one of the four ways
	typedef logic [1:0] way_t;

	// states of the cache controller FSM
	typedef enum logic [2:0]
	{
		state_idle,
		state_lookup,
		state_fill,
		state_fill_done,
		state_respond,
		state_invalidate
	} ctrl_state_t;

endpackage

/* source/cache_tag_mem.sv */
module cache_tag_mem
(
	input  logic                                 clk,
	input  logic                                 rst_n_i,
	input  logic [31:0]                          address_i,
	input  logic                                 access_i,
	output cache_pkg::way_t                      hit_way_o,
	output logic                                 cache_hit_o,
	input  logic                                 update_i,
	input  logic                                 invalidate_i,
	input  cache_pkg::way_t                      update_way_i,
	input  logic [cache_pkg::tag_width-1:0]      update_tag_i,
	input  logic [cache_pkg::set_index_width-1:0] update_set_i
);
	import cache_pkg::*;

	// one tag bank and one valid bank per way, all read in parallel
	logic [tag_width-1:0] tag_mem [num_ways][num_sets];
	logic [num_sets-1:0]  valid_mem [num_ways];

	logic [tag_width-1:0] tag_q [num_ways];
	logic [num_ways-1:0]  valid_q;
	logic                 access_latched;
	logic [tag_width-1:0] request_tag_latched;
	logic [num_ways-1:0]  way_hit;

	logic [set_index_width-1:0] requested_set;
	logic [tag_width-1:0]       requested_tag;

	assign requested_set = address_i[word_offset_width + 2 +: set_index_width];
	assign requested_tag = address_i[31 -: tag_width];

	// registered lookup, the result is compared in the following cycle
	always_ff @(posedge clk)
	begin
		for (int w = 0; w < num_ways; w++)
		begin
			tag_q[w] <= tag_mem[w][requested_set];
			valid_q[w] <= valid_mem[w][requested_set];
		end
		request_tag_latched <= requested_tag;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
			access_latched <= 1'b0;
		else
			access_latched <= access_i;
	end

	always_comb
	begin
		for (int w = 0; w < num_ways; w++)
			way_hit[w] = valid_q[w] && (tag_q[w] == request_tag_latched);
	end

	// the lowest matching way wins if more than one matches
	always_comb
	begin
		hit_way_o = '0;
		for (int w = num_ways - 1; w >= 0; w--)
		begin
			if (way_hit[w])
				hit_way_o = way_t'(w);
		end
	end

	assign cache_hit_o = (|way_hit) && access_latched;

	always_ff @(posedge clk)
	begin
		if (update_i)
			tag_mem[update_way_i][update_set_i] <= update_tag_i;
	end

	// an update marks the line valid, an invalidate clears it
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			for (int w = 0; w < num_ways; w++)
				valid_mem[w] <= '0;
		end
		else if (update_i)
			valid_mem[update_way_i][update_set_i] <= 1'b1;
		else if (invalidate_i)
			valid_mem[update_way_i][update_set_i] <= 1'b0;
	end

endmodule

/* source/cache_data_mem.sv */
module cache_data_mem
(
	input  logic                                   clk,
	input  logic [cache_pkg::set_index_width-1:0]  rd_set_i,
	input  cache_pkg::way_t                        rd_way_i,
	input  logic [cache_pkg::word_offset_width-1:0] rd_word_i,
	output logic [31:0]                            rd_data_o,
	input  logic                                   wr_en_i,
	input  logic [cache_pkg::set_index_width-1:0]  wr_set_i,
	input  cache_pkg::way_t                        wr_way_i,
	input  logic [cache_pkg::word_offset_width-1:0] wr_word_i,
	input  logic [31:0]                            wr_data_i
);
	import cache_pkg::*;

	localparam int addr_width = $bits(way_t) + set_index_width + word_offset_width;

	// all ways share one array, indexed by way, set and word
	logic [31:0] ram [num_ways * num_sets * line_words];

	logic [addr_width-1:0] rd_addr;
	logic [addr_width-1:0] wr_addr;

	assign rd_addr = {rd_way_i, rd_set_i, rd_word_i};
	assign wr_addr = {wr_way_i, wr_set_i, wr_word_i};

	always_ff @(posedge clk)
	begin
		if (wr_en_i)
			ram[wr_addr] <= wr_data_i;
	end

	// read data appears one cycle after the address
	always_ff @(posedge clk)
	begin
		rd_data_o <= ram[rd_addr];
	end

endmodule

/* source/cache_lru.sv */
module cache_lru
(
	input  logic                                  clk,
	input  logic                                  rst_n_i,
	input  logic [cache_pkg::set_index_width-1:0] set_i,
	input  logic                                  touch_i,
	input  cache_pkg::way_t                       touch_way_i,
	output cache_pkg::way_t                       victim_way_o
);
	import cache_pkg::*;

	// bit 0 picks the pair, bit 1 picks within ways 0/1, bit 2 within ways 2/3
	logic [2:0] lru_bits [num_sets];
	logic [2:0] cur_bits;

	assign cur_bits = lru_bits[set_i];

	// follow the tree toward the least recently used way
	always_comb
	begin
		if (cur_bits[0])
			victim_way_o = {1'b1, cur_bits[2]};
		else
			victim_way_o = {1'b0, cur_bits[1]};
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			for (int s = 0; s < num_sets; s++)
				lru_bits[s] <= 3'b000;
		end
		else if (touch_i)
		begin
			// point every bit on the path away from the touched way
			lru_bits[set_i][0] <= ~touch_way_i[1];
			if (touch_way_i[1])
				lru_bits[set_i][2] <= ~touch_way_i[0];
			else
				lru_bits[set_i][1] <= ~touch_way_i[0];
		end
	end

endmodule

/* source/cache_controller.sv */
module cache_controller
(
	input  logic                                    clk,
	input  logic                                    rst_n_i,
	input  logic                                    cpu_cyc_i,
	input  logic                                    cpu_stb_i,
	input  logic                                    cpu_we_i,
	input  logic [31:0]                             cpu_adr_i,
	output logic                                    cpu_ack_o,
	output logic                                    mem_cyc_o,
	output logic                                    mem_stb_o,
	output logic [31:0]                             mem_adr_o,
	input  logic                                    mem_ack_i,
	output logic                                    tag_access_o,
	output logic                                    tag_update_o,
	output logic                                    tag_invalidate_o,
	output cache_pkg::way_t                         tag_way_o,
	input  logic                                    cache_hit_i,
	input  cache_pkg::way_t                         hit_way_i,
	input  cache_pkg::way_t                         victim_way_i,
	output logic                                    lru_touch_o,
	output cache_pkg::way_t                         lru_way_o,
	output logic                                    data_wr_en_o,
	output cache_pkg::way_t                         data_way_o,
	output logic [cache_pkg::word_offset_width-1:0] data_word_o
);
	import cache_pkg::*;

	ctrl_state_t                  state_q;
	way_t                         way_q;
	logic [word_offset_width-1:0] fill_count;
	logic                         mem_stb_q;
	logic                         fill_word_done;
	logic                         fill_last;

	// a fill word completes when its strobe is acknowledged
	assign fill_word_done = (state_q == state_fill) && mem_stb_q && mem_ack_i;
	assign fill_last = fill_word_done && (fill_count == word_offset_width'(line_words - 1));

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			state_q <= state_idle;
			way_q <= '0;
			fill_count <= '0;
			mem_stb_q <= 1'b0;
		end
		else
		begin
			case (state_q)
				state_idle:
				begin
					if (cpu_cyc_i && cpu_stb_i)
						state_q <= state_lookup;
				end

				state_lookup:
				begin
					if (cache_hit_i)
					begin
						way_q <= hit_way_i;
						state_q <= cpu_we_i ? state_invalidate : state_respond;
					end
					else if (cpu_we_i)
						state_q <= state_respond;
					else
					begin
						// miss, so the victim way receives the new line
						way_q <= victim_way_i;
						fill_count <= '0;
						mem_stb_q <= 1'b1;
						state_q <= state_fill;
					end
				end

				state_fill:
				begin
					if (fill_word_done)
					begin
						mem_stb_q <= 1'b0;
						fill_count <= fill_count + 1'b1;
						if (fill_last)
							state_q <= state_fill_done;
					end
					else if (!mem_stb_q)
						mem_stb_q <= 1'b1;
				end

				state_fill_done:
					state_q <= state_respond;

				state_respond, state_invalidate:
					state_q <= state_idle;

				default:
					state_q <= state_idle;
			endcase
		end
	end

	assign tag_access_o = (state_q == state_idle) && cpu_cyc_i && cpu_stb_i;
	assign tag_update_o = fill_last;
	assign tag_invalidate_o = (state_q == state_invalidate);
	assign tag_way_o = way_q;

	// writes acknowledge in invalidate so hits and misses take the same time
	assign cpu_ack_o = (state_q == state_respond) || (state_q == state_invalidate);

	assign mem_cyc_o = (state_q == state_fill);
	assign mem_stb_o = (state_q == state_fill) && mem_stb_q;
	assign mem_adr_o = {cpu_adr_i[31:word_offset_width + 2], fill_count, 2'b00};

	// reads that hit and completed fills both count as a use of the way
	assign lru_touch_o = ((state_q == state_lookup) && cache_hit_i && !cpu_we_i)
		|| (state_q == state_fill_done);
	assign lru_way_o = (state_q == state_lookup) ? hit_way_i : way_q;

	assign data_wr_en_o = fill_word_done;
	assign data_way_o = way_q;
	assign data_word_o = fill_count;

endmodule

/* source/cache_top.sv */
module cache_top
(
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic        cpu_cyc_i,
	input  logic        cpu_stb_i,
	input  logic        cpu_we_i,
	input  logic [31:0] cpu_adr_i,
	output logic [31:0] cpu_dat_o,
	output logic        cpu_ack_o,
	output logic        mem_cyc_o,
	output logic        mem_stb_o,
	output logic [31:0] mem_adr_o,
	input  logic [31:0] mem_dat_i,
	input  logic        mem_ack_i
);
	import cache_pkg::*;

	logic [tag_width-1:0]         req_tag;
	logic [set_index_width-1:0]   req_set;
	logic [word_offset_width-1:0] req_word;

	logic tag_access;
	logic tag_update;
	logic tag_invalidate;
	way_t tag_way;
	logic cache_hit;
	way_t hit_way;
	way_t victim_way;
	logic lru_touch;
	way_t lru_way;
	logic data_wr_en;
	way_t data_way;
	logic [word_offset_width-1:0] data_word;
	way_t rd_way;

	assign req_tag = cpu_adr_i[31 -: tag_width];
	assign req_set = cpu_adr_i[word_offset_width + 2 +: set_index_width];
	assign req_word = cpu_adr_i[2 +: word_offset_width];

	// a live hit selects its way, otherwise read back the filled line
	assign rd_way = cache_hit ? hit_way : data_way;

	cache_controller i_cache_controller
	(
		.clk              (clk),
		.rst_n_i          (rst_n_i),
		.cpu_cyc_i        (cpu_cyc_i),
		.cpu_stb_i        (cpu_stb_i),
		.cpu_we_i         (cpu_we_i),
		.cpu_adr_i        (cpu_adr_i),
		.cpu_ack_o        (cpu_ack_o),
		.mem_cyc_o        (mem_cyc_o),
		.mem_stb_o        (mem_stb_o),
		.mem_adr_o        (mem_adr_o),
		.mem_ack_i        (mem_ack_i),
		.tag_access_o     (tag_access),
		.tag_update_o     (tag_update),
		.tag_invalidate_o (tag_invalidate),
		.tag_way_o        (tag_way),
		.cache_hit_i      (cache_hit),
		.hit_way_i        (hit_way),
		.victim_way_i     (victim_way),
		.lru_touch_o      (lru_touch),
		.lru_way_o        (lru_way),
		.data_wr_en_o     (data_wr_en),
		.data_way_o       (data_way),
		.data_word_o      (data_word)
	);

	cache_tag_mem i_cache_tag_mem
	(
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.address_i    (cpu_adr_i),
		.access_i     (tag_access),
		.hit_way_o    (hit_way),
		.cache_hit_o  (cache_hit),
		.update_i     (tag_update),
		.invalidate_i (tag_invalidate),
		.update_way_i (tag_way),
		.update_tag_i (req_tag),
		.update_set_i (req_set)
	);

	cache_data_mem i_cache_data_mem
	(
		.clk       (clk),
		.rd_set_i  (req_set),
		.rd_way_i  (rd_way),
		.rd_word_i (req_word),
		.rd_data_o (cpu_dat_o),
		.wr_en_i   (data_wr_en),
		.wr_set_i  (req_set),
		.wr_way_i  (data_way),
		.wr_word_i (data_word),
		.wr_data_i (mem_dat_i)
	);

	cache_lru i_cache_lru
	(
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.set_i        (req_set),
		.touch_i      (lru_touch),
		.touch_way_i  (lru_way),
		.victim_way_o (victim_way)
	);

endmodule

/* bench/tb_mem_model.sv */
module tb_mem_model
(
	input  logic        clk,
	input  logic        cyc_i,
	input  logic        stb_i,
	input  logic [31:0] adr_i,
	output logic [31:0] dat_o,
	output logic        ack_o,
	output int          read_count_o
);
	timeunit 1ns;
	timeprecision 1ps;

	int delay_left;
	bit pending;

	// every word holds its own byte address inverted, so each location is distinct
	initial
	begin
		void'($urandom(32));
		dat_o = '0;
		ack_o = 1'b0;
		read_count_o = 0;
		delay_left = 0;
		pending = 1'b0;
		forever
		begin
			@(posedge clk);
			#1;
			// ack is a single cycle pulse, the master drops stb before the next word
			if (ack_o)
				ack_o = 1'b0;
			else if (cyc_i && stb_i)
			begin
				if (!pending)
				begin
					pending = 1'b1;
					delay_left = $urandom % 4;
				end
				if (delay_left == 0)
				begin
					dat_o = ~adr_i;
					ack_o = 1'b1;
					read_count_o++;
					pending = 1'b0;
				end
				else
					delay_left--;
			end
		end
	end

endmodule

/* bench/tb_cache_top.sv */
module tb_cache_top;
	timeunit 1ns;
	timeprecision 1ps;

	import cache_pkg::*;

	localparam int op_read = 0;
	localparam int op_write = 1;
	localparam int op_reset = 2;
	localparam int hit_latency = 3;

	logic        clk = 1'b0;
	logic        rst_n_i;
	logic        cpu_cyc_i;
	logic        cpu_stb_i;
	logic        cpu_we_i;
	logic [31:0] cpu_adr_i;
	logic [31:0] cpu_dat_o;
	logic        cpu_ack_o;
	logic        mem_cyc_o;
	logic        mem_stb_o;
	logic [31:0] mem_adr_o;
	logic [31:0] mem_dat_i;
	logic        mem_ack_i;
	int          read_count;

	int          case_op[$];
	logic [31:0] case_addr[$];
	logic [31:0] case_data[$];
	int          case_fills[$];
	way_t        case_way[$];

	int test_errors = 0;
	int pass_count = 0;
	int fail_count = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	always #5 clk = ~clk;

	cache_top i_cache_top
	(
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.cpu_cyc_i (cpu_cyc_i),
		.cpu_stb_i (cpu_stb_i),
		.cpu_we_i  (cpu_we_i),
		.cpu_adr_i (cpu_adr_i),
		.cpu_dat_o (cpu_dat_o),
		.cpu_ack_o (cpu_ack_o),
		.mem_cyc_o (mem_cyc_o),
		.mem_stb_o (mem_stb_o),
		.mem_adr_o (mem_adr_o),
		.mem_dat_i (mem_dat_i),
		.mem_ack_i (mem_ack_i)
	);

	tb_mem_model i_tb_mem_model
	(
		.clk          (clk),
		.cyc_i        (mem_cyc_o),
		.stb_i        (mem_stb_o),
		.adr_i        (mem_adr_o),
		.dat_o        (mem_dat_i),
		.ack_o        (mem_ack_i),
		.read_count_o (read_count)
	);

	task automatic check_data(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
			test_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			test_errors++;
		end
	endtask

	task automatic check_fill(input string name, input int actual, input int expected);
		if (actual != expected)
		begin
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			test_errors++;
		end
	endtask

	task automatic check_way(input string name, input way_t actual, input way_t expected);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			test_errors++;
		end
	endtask

	task automatic check_latency(input string name, input int actual, input int expected);
		if (actual != expected)
		begin
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			test_errors++;
		end
	endtask

	function automatic string op_label(input int op);
		if (op == op_read)
			return "read";
		else if (op == op_write)
			return "write";
		return "reset";
	endfunction

	task automatic report_result(input string what);
		if (test_errors == 0)
		begin
			pass_count++;
			$display("%s: ok", what);
		end
		else
		begin
			fail_count++;
			$display("%s: %0d errors", what, test_errors);
		end
	endtask

	task automatic load_cases(output bit ok);
		int                fd;
		int                code;
		logic [8*8-1:0]    op_text;
		logic [8*160-1:0]  rest_of_line;
		logic [31:0]       addr;
		logic [31:0]       data;
		int                fills;
		int                way;
		ok = 1'b0;
		fd = $fopen("bench/cache_cases.txt", "r");
		if (fd == 0)
		begin
			$display("the case file bench/cache_cases.txt could not be opened");
			return;
		end
		while (!$feof(fd))
		begin
			code = $fscanf(fd, "%s", op_text);
			if (code == 1 && op_text == "#")
				code = $fgets(rest_of_line, fd);
			else if (code == 1)
			begin
				code = $fscanf(fd, "%h %h %d %d", addr, data, fills, way);
				if (code != 4 || !(op_text == "read" || op_text == "write" || op_text == "reset"))
				begin
					$display("a line of the case file is malformed");
					$fclose(fd);
					return;
				end
				case_op.push_back(op_text == "read" ? op_read :
					(op_text == "write" ? op_write : op_reset));
				case_addr.push_back(addr);
				case_data.push_back(data);
				case_fills.push_back(fills);
				case_way.push_back(way_t'(way));
			end
		end
		$fclose(fd);
		ok = (case_op.size() > 0);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#1;
		rst_n_i = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst_n_i = 1'b1;
	endtask

	// one processor cycle, held until ack, with outputs sampled at the falling edge
	task automatic cpu_access(input logic we, input logic [31:0] addr,
		output logic [31:0] data, output int cycles, output way_t fill_way);
		logic ack_seen;
		logic word_acked;
		@(posedge clk);
		#1;
		cpu_cyc_i = 1'b1;
		cpu_stb_i = 1'b1;
		cpu_we_i = we;
		cpu_adr_i = addr;
		cycles = 0;
		fill_way = '0;
		ack_seen = 1'b0;
		word_acked = 1'b0;
		while (!ack_seen)
		begin
			@(negedge clk);
			cycles++;
			if (mem_cyc_o)
				fill_way = i_cache_top.data_way;
			// stb goes low for a cycle after every acknowledged word
			if (word_acked)
				check_flag("mem_stb_o", mem_stb_o, 1'b0);
			word_acked = mem_stb_o && mem_ack_i;
			ack_seen = cpu_ack_o;
		end
		data = cpu_dat_o;
		@(posedge clk);
		#1;
		cpu_cyc_i = 1'b0;
		cpu_stb_i = 1'b0;
		cpu_we_i = 1'b0;
		// ack lasts a single cycle
		@(negedge clk);
		check_flag("cpu_ack_o", cpu_ack_o, 1'b0);
	endtask

	task automatic run_case(input int idx);
		logic [31:0] data;
		int          cycles;
		way_t        fill_way;
		int          reads_before;
		test_errors = 0;
		reads_before = read_count;
		if (case_op[idx] == op_reset)
			apply_reset();
		else
		begin
			cpu_access(case_op[idx] == op_write, case_addr[idx], data, cycles, fill_way);
			if (case_op[idx] == op_read)
				check_data("cpu_dat_o", data, case_data[idx]);
			check_fill("read_count", read_count - reads_before, case_fills[idx]);
			// a fill stretches the latency, so only hits and writes have a fixed one
			if (case_fills[idx] > 0)
				check_way("data_way", fill_way, case_way[idx]);
			else
				check_latency("cpu_ack_o cycles", cycles, hit_latency);
		end
		report_result($sformatf("test %0d %s 0x%08h", idx + 1, op_label(case_op[idx]),
			case_addr[idx]));
	endtask

	// worst case is a full line fill per case with up to five cycles per word
	initial
	begin
		wait (cycle_limit > 0);
		while (cycle_count < cycle_limit)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout after %0d cycles, the controller is stuck in state %s",
			cycle_count, i_cache_top.i_cache_controller.state_q.name());
		$display("Regression failed");
		$finish;
	end

	initial
	begin
		bit loaded;
		rst_n_i = 1'b0;
		cpu_cyc_i = 1'b0;
		cpu_stb_i = 1'b0;
		cpu_we_i = 1'b0;
		cpu_adr_i = '0;
		load_cases(loaded);
		if (!loaded)
		begin
			$display("no cases could be read, nothing was run");
			fail_count++;
		end
		else
		begin
			cycle_limit = case_op.size() * line_words * 5 + 200;
			repeat (2) @(posedge clk);
			#1;
			rst_n_i = 1'b1;
			// both ports are quiet once reset is released
			test_errors = 0;
			@(negedge clk);
			check_flag("cpu_ack_o", cpu_ack_o, 1'b0);
			check_flag("mem_cyc_o", mem_cyc_o, 1'b0);
			check_flag("mem_stb_o", mem_stb_o, 1'b0);
			report_result("outputs after reset");
			for (int i = 0; i < case_op.size(); i++)
				run_case(i);
		end
		$display("%0d tests run, %0d passed, %0d with errors", pass_count + fail_count,
			pass_count, fail_count);
		if (fail_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* flist.f */
source/cache_pkg.sv
source/cache_tag_mem.sv
source/cache_data_mem.sv
source/cache_lru.sv
source/cache_controller.sv
source/cache_top.sv
bench/tb_mem_model.sv
bench/tb_cache_top.sv

/* bench/cache_cases.txt */
# op addr data fills way
# data is checked on reads, way is the expected fill way when fills is 16
read 000008C0 FFFFF73F 16 0
read 000008E4 FFFFF71B 0 0
read 000008FC FFFFF703 0 0
read 000010C4 FFFFEF3B 16 2
read 000018C8 FFFFE737 16 1
read 000020CC FFFFDF33 16 3
read 000008C0 FFFFF73F 0 0
read 000028C0 FFFFD73F 16 2
read 000008C0 FFFFF73F 0 0
read 000010C4 FFFFEF3B 16 3
read 000028C0 FFFFD73F 0 0
write 000008C0 00000000 0 0
read 000008D0 FFFFF72F 16 1
write 00005000 00000000 0 0
read 000008D0 FFFFF72F 0 0
read 00030040 FFFCFFBF 16 0
read 00030080 FFFCFF7F 16 0
read 00030100 FFFCFEFF 16 0
read 00030044 FFFCFFBB 0 0
read 00030088 FFFCFF77 0 0
read 0003013C FFFCFEC3 0 0
reset 00000000 00000000 0 0
read 00030044 FFFCFFBB 16 0
read 000028C0 FFFFD73F 16 0
read 000028C4 FFFFD73B 0 0
